//--- Makefile
# Verilator build and run for the SPI echo endpoint

VERILATOR  ?= verilator
TB_TOP     ?= spi_echo_tb
RTL_TOP    ?= spi_echo_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= -j 0
LINT_FLAGS ?= -Wall
FAIL_MSG   := Something failed
SOURCES    := $(wildcard logic/*.sv logic/*.svh bench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert --top-module $(TB_TOP) \
	  -Mdir $(BUILD_DIR) $(VFLAGS) -f $(FILELIST)

run: build
	@./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/spi_echo_tb.sv
// Testbench for the SPI echo endpoint
// Acts as a mode 0 SPI master that bit-bangs random frames, and checks each
// reply and the sticky status flags against a queue model of the reply FIFO

`timescale 1ns/1ps
`default_nettype none

`include "spi_echo_defines.svh"

module spi_echo_tb;

  localparam int WBITS         = `SPI_WORD_BITS;
  localparam int DEPTH         = 4;
  localparam int HALF          = 4;
  localparam int CS_SETUP      = 6;
  localparam int CS_HOLD       = 6;
  localparam int SETTLE        = 4;
  localparam int GAP_MIN       = 4;
  localparam int GAP_MAX       = 24;
  localparam int RESET_CYCLES  = 16;
  localparam int RANDOM_FRAMES = 200;
  localparam int BURST_FRAMES  = 6;
  localparam int SHORT_ROUNDS  = 8;
  localparam int TOTAL_FRAMES  = 1 + RANDOM_FRAMES + BURST_FRAMES + 2 * SHORT_ROUNDS + DEPTH + 2;
  // Worst case length of one frame, from select low to the end of its idle gap
  localparam int FRAME_CYCLES  = CS_SETUP + WBITS * 2 * HALF + CS_HOLD + SETTLE + GAP_MAX;
  localparam int MAX_CYCLES    = (RESET_CYCLES + TOTAL_FRAMES * FRAME_CYCLES) * 3 / 2;
  localparam spi_echo_pkg::spi_word_t DEFAULT_REPLY = 16'hCAFE;

  logic clk;
  logic rst_n;
  logic sclk;
  logic mosi;
  logic cs_n;
  logic miso;
  spi_echo_pkg::link_status_t status;

  // Reference model of the reply queue and the sticky flags
  spi_echo_pkg::spi_word_t model_q[$];
  logic exp_overflow;
  logic exp_short;
  int   errors;
  int   checks;
  int   cycles;

  spi_echo_top UUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .sclk   (sclk),
    .mosi   (mosi),
    .cs_n   (cs_n),
    .miso   (miso),
    .status (status)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ************************************************************
  // Checks
  // ************************************************************

  task automatic check_word(input string sig, input spi_echo_pkg::spi_word_t got,
                            input spi_echo_pkg::spi_word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t: %s = 0x%h, expected 0x%h", $time, sig, got, exp);
    end
  endtask

  task automatic check_bit(input string sig, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t: %s = %b, expected %b", $time, sig, got, exp);
    end
  endtask

  // ************************************************************
  // SPI master
  // ************************************************************

  // Shifts out the first nbits of word MSB first; miso is captured just as
  // sclk rises, which is where a mode 0 master samples it
  task automatic run_frame(input spi_echo_pkg::spi_word_t word, input int nbits,
                           output spi_echo_pkg::spi_word_t reply);
    int i;
    reply = '0;
    cs_n  = 1'b0;
    mosi  = word[WBITS-1];
    repeat (CS_SETUP) @(negedge clk);
    for (i = 0; i < nbits; i++) begin
      // Data changes together with the falling sclk edge
      if (i != 0) begin
        mosi = word[WBITS-1-i];
        repeat (HALF) @(negedge clk);
      end
      reply[WBITS-1-i] = miso;
      sclk = 1'b1;
      repeat (HALF) @(negedge clk);
      sclk = 1'b0;
    end
    repeat (CS_HOLD) @(negedge clk);
    cs_n = 1'b1;
    mosi = 1'b0;
  endtask

  // One frame against the model, with its reply and status checked
  task automatic exchange_frame(input spi_echo_pkg::spi_word_t word, input int nbits,
                                input int gap, output spi_echo_pkg::spi_word_t reply);
    spi_echo_pkg::spi_word_t expected;
    spi_echo_pkg::spi_word_t mask;
    // The endpoint pops at frame start, before this frame's own word arrives
    if (model_q.size() > 0) begin
      expected = model_q.pop_front();
    end else begin
      expected = DEFAULT_REPLY;
    end
    run_frame(word, nbits, reply);
    if (nbits == WBITS) begin
      if (model_q.size() < DEPTH) begin
        model_q.push_back(word);
      end else begin
        exp_overflow = 1'b1;
      end
    end else begin
      exp_short = 1'b1;
    end
    // Only the bits that were clocked are compared
    mask = {WBITS{1'b1}} << (WBITS - nbits);
    check_word("miso reply", reply & mask, expected & mask);
    repeat (SETTLE) @(negedge clk);
    check_bit("miso", miso, 1'b0);
    check_bit("status.overflow", status.overflow, exp_overflow);
    check_bit("status.short_frame", status.short_frame, exp_short);
    repeat (gap) @(negedge clk);
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial begin
    spi_echo_pkg::spi_word_t reply;
    int k;
    void'($urandom(32'h1939_c972));
    rst_n        = 1'b0;
    sclk         = 1'b0;
    mosi         = 1'b0;
    cs_n         = 1'b1;
    exp_overflow = 1'b0;
    exp_short    = 1'b0;
    errors       = 0;
    checks       = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) @(negedge clk);

    // Idle state straight out of reset
    check_bit("miso", miso, 1'b0);
    check_bit("status.overflow", status.overflow, 1'b0);
    check_bit("status.short_frame", status.short_frame, 1'b0);

    // Nothing is queued yet, so the first reply is the default word
    exchange_frame(spi_echo_pkg::spi_word_t'($urandom), WBITS, GAP_MIN, reply);
    check_word("miso reply", reply, DEFAULT_REPLY);

    for (k = 0; k < RANDOM_FRAMES; k++) begin
      exchange_frame(spi_echo_pkg::spi_word_t'($urandom), WBITS,
                     $urandom_range(GAP_MIN, GAP_MAX), reply);
    end

    // Back to back frames with the shortest gap
    // Every frame opens with a pop, so the queue only grows while it is empty
    for (k = 0; k < BURST_FRAMES; k++) begin
      exchange_frame(spi_echo_pkg::spi_word_t'($urandom), WBITS, GAP_MIN, reply);
    end

    // Cut-off frames, each following a full frame so that it pops a real word
    for (k = 0; k < SHORT_ROUNDS; k++) begin
      exchange_frame(spi_echo_pkg::spi_word_t'($urandom), WBITS,
                     $urandom_range(GAP_MIN, GAP_MAX), reply);
      exchange_frame(spi_echo_pkg::spi_word_t'($urandom), $urandom_range(1, WBITS - 1),
                     $urandom_range(GAP_MIN, GAP_MAX), reply);
    end

    // Short frames pop without pushing, so they empty the queue
    for (k = 0; k < DEPTH && model_q.size() > 0; k++) begin
      exchange_frame(spi_echo_pkg::spi_word_t'($urandom), $urandom_range(1, WBITS - 1),
                     GAP_MIN, reply);
    end
    exchange_frame(spi_echo_pkg::spi_word_t'($urandom), WBITS, GAP_MIN, reply);
    check_word("miso reply", reply, DEFAULT_REPLY);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog sized from the worst case length of every frame in the run
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/spi_echo_pkg.sv
logic/spi_frame_receiver.sv
logic/reply_fifo.sv
logic/spi_reply_transmitter.sv
logic/spi_echo_top.sv
bench/spi_echo_tb.sv

//--- logic/reply_fifo.sv
// Reply word queue
// Circular buffer between the frame receiver and the reply transmitter,
// drops pushes when full and keeps a sticky overflow flag

`timescale 1ns/1ps
`default_nettype none

`include "spi_echo_defines.svh"

module reply_fifo (
  input  wire                       clk,
  input  wire                       rst_n,
  input  spi_echo_pkg::rx_word_t    push,
  input  wire                       pop,
  output spi_echo_pkg::spi_word_t   head,
  output logic                      empty,
  output logic                      overflow
);

  localparam int PTR_W = `SPI_FIFO_DEPTH_LOG2;
  localparam int DEPTH = 1 << PTR_W;

  spi_echo_pkg::spi_word_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             do_push;
  logic             do_pop;
  logic             overflow_q;

  assign full    = (count == (PTR_W + 1)'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push.valid & ~full;
  assign do_pop  = pop & ~empty;

  // ************************************************************
  // Pointers, occupancy and overflow
  // ************************************************************

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + PTR_W'(1);
      if (do_pop)  rd_ptr <= rd_ptr + PTR_W'(1);
      case ({do_push, do_pop})
        2'b10:   count <= count + (PTR_W + 1)'(1);
        2'b01:   count <= count - (PTR_W + 1)'(1);
        default: count <= count;
      endcase
      // A word arriving with no room is lost, remember that it happened
      if (push.valid && full) overflow_q <= 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push.data;
  end

  // Oldest entry is always visible, one cycle after it was written
  assign head     = mem[rd_ptr];
  assign overflow = overflow_q;

  // The transmitter checks empty before it pops
  a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !empty)
    else $error("pop while FIFO empty");

  a_count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    count <= (PTR_W + 1)'(DEPTH))
    else $error("FIFO count %0d above depth", count);

endmodule

`default_nettype wire

//--- logic/spi_echo_defines.svh
// SPI echo endpoint build constants
// Frame length, reply queue depth, empty-queue reply word and synchronizer depth
// shared by the package and the RTL blocks

`ifndef SPI_ECHO_DEFINES_SVH
`define SPI_ECHO_DEFINES_SVH

// ************************************************************
// Frame format
// ************************************************************

// Bits per SPI frame, which is also the width of one queued word
`define SPI_WORD_BITS 16

// Word shifted out on miso when nothing is waiting in the queue
`define SPI_DEFAULT_REPLY 16'hCAFE

// ************************************************************
// Reply queue and input sampling
// ************************************************************

// Queue depth as a power of two, 2 gives four entries
`define SPI_FIFO_DEPTH_LOG2 2

// Flops in each pin synchronizer, must be at least 2
// Together with the edge detect flop this sets the pin-to-event latency
`define SPI_SYNC_STAGES 2

`endif

//--- logic/spi_echo_pkg.sv
// SPI echo endpoint shared types
// Data word, receiver and status bundles, and the state encodings of the
// receiver and transmitter FSMs

`default_nettype none

`include "spi_echo_defines.svh"

package spi_echo_pkg;

  // One frame worth of data, MSB is the first bit on the wire
  typedef logic [`SPI_WORD_BITS-1:0] spi_word_t;

  // A completed frame from the receiver
  // valid is a single-cycle push strobe toward the reply queue
  typedef struct packed {
    logic      valid;
    spi_word_t data;
  } rx_word_t;

  // Chip select edges as seen after synchronization
  // Each field is a one-cycle pulse in the clk domain
  typedef struct packed {
    logic frame_start;
    logic frame_end;
  } frame_event_t;

  // Sticky error flags, both cleared only by reset
  typedef struct packed {
    logic overflow;
    logic short_frame;
  } link_status_t;

  // Receiver FSM: waiting for cs_n, collecting bits, waiting for cs_n release
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_SHIFT,
    RX_WAIT_END
  } rx_state_e;

  // Transmitter FSM: idle, one cycle to fetch the reply, then shifting out
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_LOAD,
    TX_SHIFT
  } tx_state_e;

endpackage

`default_nettype wire

//--- logic/spi_echo_top.sv
// SPI echo endpoint top level
// Receives words from an SPI master, queues them, and returns the oldest
// queued word in the following frame, or 0xCAFE when the queue is empty

`timescale 1ns/1ps
`default_nettype none

module spi_echo_top (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         sclk,
  input  wire                         mosi,
  input  wire                         cs_n,
  output logic                        miso,
  output spi_echo_pkg::link_status_t  status
);

  // Receiver to queue and transmitter
  spi_echo_pkg::rx_word_t      rx_word;
  spi_echo_pkg::frame_event_t  frame_event;
  logic                        fall_strobe;
  logic                        short_frame;

  // Queue to transmitter and back
  spi_echo_pkg::spi_word_t     head;
  logic                        empty;
  logic                        pop;
  logic                        overflow;

  spi_frame_receiver u_receiver (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .mosi        (mosi),
    .cs_n        (cs_n),
    .rx_word     (rx_word),
    .frame_event (frame_event),
    .fall_strobe (fall_strobe),
    .short_frame (short_frame)
  );

  reply_fifo u_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (rx_word),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .overflow (overflow)
  );

  spi_reply_transmitter u_transmitter (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_event (frame_event),
    .fall_strobe (fall_strobe),
    .head        (head),
    .empty       (empty),
    .pop         (pop),
    .miso        (miso)
  );

  // Both flags are sticky at their source
  assign status.overflow    = overflow;
  assign status.short_frame = short_frame;

endmodule

`default_nettype wire

//--- logic/spi_frame_receiver.sv
// SPI mode 0 frame receiver
// Brings sclk, mosi and cs_n into the clk domain, finds their edges and
// assembles mosi into words, MSB first, on each rising sclk edge

`timescale 1ns/1ps
`default_nettype none

`include "spi_echo_defines.svh"

module spi_frame_receiver (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         sclk,
  input  wire                         mosi,
  input  wire                         cs_n,
  output spi_echo_pkg::rx_word_t      rx_word,
  output spi_echo_pkg::frame_event_t  frame_event,
  output logic                        fall_strobe,
  output logic                        short_frame
);

  localparam int SYNC  = `SPI_SYNC_STAGES;
  localparam int WBITS = `SPI_WORD_BITS;
  localparam int CNT_W = $clog2(WBITS);

  // ************************************************************
  // Pin synchronizers and edge detection
  // ************************************************************

  logic [SYNC-1:0] sclk_sync;
  logic [SYNC-1:0] mosi_sync;
  logic [SYNC-1:0] cs_n_sync;
  logic            sclk_q;
  logic            cs_n_q;

  // Reset values match the idle bus, so no false edges come out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_sync <= '0;
      mosi_sync <= '0;
      cs_n_sync <= '1;
      sclk_q    <= 1'b0;
      cs_n_q    <= 1'b1;
    end else begin
      sclk_sync <= {sclk_sync[SYNC-2:0], sclk};
      mosi_sync <= {mosi_sync[SYNC-2:0], mosi};
      cs_n_sync <= {cs_n_sync[SYNC-2:0], cs_n};
      sclk_q    <= sclk_sync[SYNC-1];
      cs_n_q    <= cs_n_sync[SYNC-1];
    end
  end

  logic sclk_rise;
  logic cs_fall;
  logic cs_rise;

  assign sclk_rise   = sclk_sync[SYNC-1] & ~sclk_q;
  assign cs_fall     = ~cs_n_sync[SYNC-1] & cs_n_q;
  assign cs_rise     = cs_n_sync[SYNC-1] & ~cs_n_q;

  // Left combinational so the transmitter sees edges one cycle earlier,
  // which keeps miso ahead of the next rising sclk edge
  assign fall_strobe = ~sclk_sync[SYNC-1] & sclk_q;
  assign frame_event.frame_start = cs_fall;
  assign frame_event.frame_end   = cs_rise;

  // ************************************************************
  // Frame FSM and deserializer
  // ************************************************************

  spi_echo_pkg::rx_state_e rx_state;
  spi_echo_pkg::spi_word_t shift_q;
  logic [CNT_W-1:0]        bit_cnt;
  logic                    rx_valid;
  logic                    short_frame_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_state      <= spi_echo_pkg::RX_IDLE;
      bit_cnt       <= '0;
      rx_valid      <= 1'b0;
      short_frame_q <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (rx_state)
        spi_echo_pkg::RX_IDLE: begin
          if (cs_fall) begin
            bit_cnt  <= '0;
            rx_state <= spi_echo_pkg::RX_SHIFT;
          end
        end
        spi_echo_pkg::RX_SHIFT: begin
          // Select released before the word completed, drop what was collected
          if (cs_rise) begin
            short_frame_q <= 1'b1;
            rx_state      <= spi_echo_pkg::RX_IDLE;
          end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + CNT_W'(1);
            if (bit_cnt == CNT_W'(WBITS - 1)) begin
              rx_valid <= 1'b1;
              rx_state <= spi_echo_pkg::RX_WAIT_END;
            end
          end
        end
        // Any extra clocks in a long frame are ignored here
        spi_echo_pkg::RX_WAIT_END: begin
          if (cs_rise) rx_state <= spi_echo_pkg::RX_IDLE;
        end
        default: rx_state <= spi_echo_pkg::RX_IDLE;
      endcase
    end
  end

  // The last bit lands on the same edge that raises rx_valid
  always_ff @(posedge clk) begin
    if (rx_state == spi_echo_pkg::RX_SHIFT && sclk_rise) begin
      shift_q <= {shift_q[WBITS-2:0], mosi_sync[SYNC-1]};
    end
  end

  assign rx_word.valid = rx_valid;
  assign rx_word.data  = shift_q;
  assign short_frame   = short_frame_q;

  // In mode 0 the clock idles low, so a frame opens with sclk low
  a_frame_start_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    frame_event.frame_start |-> !sclk_sync[SYNC-1])
    else $error("cs_n fell while sclk was high");

endmodule

`default_nettype wire

//--- logic/spi_reply_transmitter.sv
// SPI mode 0 reply transmitter
// Fetches the oldest queued word, or the default reply, when a frame opens
// and shifts it out on miso MSB first, one bit per falling sclk edge

`timescale 1ns/1ps
`default_nettype none

`include "spi_echo_defines.svh"

module spi_reply_transmitter (
  input  wire                         clk,
  input  wire                         rst_n,
  input  spi_echo_pkg::frame_event_t  frame_event,
  input  wire                         fall_strobe,
  input  spi_echo_pkg::spi_word_t     head,
  input  wire                         empty,
  output logic                        pop,
  output logic                        miso
);

  localparam int WBITS = `SPI_WORD_BITS;

  spi_echo_pkg::tx_state_e tx_state;
  spi_echo_pkg::spi_word_t shift_q;

  // ************************************************************
  // Frame FSM
  // ************************************************************

  // TX_LOAD lasts exactly one cycle, long enough to take head and pop it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_state <= spi_echo_pkg::TX_IDLE;
    end else begin
      case (tx_state)
        spi_echo_pkg::TX_IDLE: begin
          if (frame_event.frame_start) tx_state <= spi_echo_pkg::TX_LOAD;
        end
        spi_echo_pkg::TX_LOAD: begin
          if (frame_event.frame_end) begin
            tx_state <= spi_echo_pkg::TX_IDLE;
          end else begin
            tx_state <= spi_echo_pkg::TX_SHIFT;
          end
        end
        spi_echo_pkg::TX_SHIFT: begin
          if (frame_event.frame_end) tx_state <= spi_echo_pkg::TX_IDLE;
        end
        default: tx_state <= spi_echo_pkg::TX_IDLE;
      endcase
    end
  end

  // ************************************************************
  // Reply shifter
  // ************************************************************

  // The master samples on rising sclk, so the next bit moves up on each fall
  always_ff @(posedge clk) begin
    if (tx_state == spi_echo_pkg::TX_LOAD) begin
      shift_q <= empty ? spi_echo_pkg::spi_word_t'(`SPI_DEFAULT_REPLY) : head;
    end else if (tx_state == spi_echo_pkg::TX_SHIFT && fall_strobe) begin
      shift_q <= {shift_q[WBITS-2:0], 1'b0};
    end
  end

  // Pop in the same cycle that head is captured
  assign pop  = (tx_state == spi_echo_pkg::TX_LOAD) && !empty;

  // Line is held low outside a frame
  assign miso = (tx_state == spi_echo_pkg::TX_SHIFT) && shift_q[WBITS-1];

  // A new frame only opens once the previous release has brought the shifter to idle
  a_idle_at_frame_start: assert property (@(posedge clk) disable iff (!rst_n)
    frame_event.frame_start |-> tx_state == spi_echo_pkg::TX_IDLE)
    else $error("transmitter not idle at frame_start");

endmodule

`default_nettype wire
